/* hw/cache_geometry_pkg.sv */
package cache_geometry_pkg;

	// word and block sizes
	localparam int WORD_W         = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int BLOCK_W        = WORD_W * WORDS_PER_LINE;

	// line count of the direct-mapped array
	localparam int LINE_COUNT = 8;

	// processor word address split into tag, index and offset
	localparam int ADDR_W     = 30;
	localparam int OFFSET_W   = 2;
	localparam int INDEX_W    = 3;
	localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
	localparam int MEM_ADDR_W = ADDR_W - OFFSET_W; // block address

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [BLOCK_W-1:0]    block_t;
	typedef logic [ADDR_W-1:0]     proc_addr_t;
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [INDEX_W-1:0]    index_t;
	typedef logic [OFFSET_W-1:0]   offset_t;

	// word view of a block, word 0 in the low bits
	typedef word_t [WORDS_PER_LINE-1:0] block_words_t;

endpackage

/* hw/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

	import cache_geometry_pkg::*;

	typedef enum logic [1:0] {
		LOOKUP     = 2'b00, // serve hits, detect misses
		WRITE_BACK = 2'b01, // dirty block out to memory
		REFILL     = 2'b10  // new block in from memory
	} ctrl_state_t;

	// per-line status entry, 27 bits
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} line_status_t;

endpackage

/* hw/line_array.sv */
`timescale 1ns/1ns

module line_array
	import cache_geometry_pkg::*;
#(
	parameter type entry_t    = block_t,
	parameter int  LINE_COUNT = cache_geometry_pkg::LINE_COUNT
)
(
	input  logic   clk,
	input  logic   proc_reset,
	input  index_t index,
	input  logic   we,
	input  entry_t wdata,
	output entry_t rdata
);

	entry_t entries [LINE_COUNT];

	// combinational read of the indexed line
	assign rdata = entries[index];

	always_ff @(posedge clk or posedge proc_reset)
	begin
		if (proc_reset)
		begin
			for (int i = 0; i < LINE_COUNT; i++)
			begin
				entries[i] <= '0;
			end
		end
		else if (we)
		begin
			entries[index] <= wdata; // one line per cycle
		end
	end

endmodule

/* hw/block_datapath.sv */
`timescale 1ns/1ns

module block_datapath
	import cache_geometry_pkg::*;
(
	input  proc_addr_t proc_addr,
	input  word_t      proc_wdata,
	input  block_t     data_rdata,
	input  block_t     mem_rdata,
	input  logic       fill_sel,
	output block_t     data_wdata,
	output word_t      rd_word
);

	offset_t      offset;
	block_words_t stored_words;
	block_words_t merged_words;
	block_t       merged_block;

	assign offset       = proc_addr[OFFSET_W-1:0];
	assign stored_words = data_rdata;

	// addressed word of the stored block
	assign rd_word = stored_words[offset];

	// replace only the addressed word
	always_comb
	begin
		for (int w = 0; w < WORDS_PER_LINE; w++)
		begin
			if (offset == offset_t'(w))
			begin
				merged_words[w] = proc_wdata;
			end
			else
			begin
				merged_words[w] = stored_words[w];
			end
		end
	end

	assign merged_block = merged_words;

	// refill takes the whole memory block
	always_comb
	begin
		if (fill_sel)
		begin
			data_wdata = mem_rdata;
		end
		else
		begin
			data_wdata = merged_block;
		end
	end

endmodule

/* hw/cache_controller.sv */
`timescale 1ns/1ns

module cache_controller
	import cache_geometry_pkg::*;
	import cache_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         proc_reset,
	input  logic         proc_read,
	input  logic         proc_write,
	input  proc_addr_t   proc_addr,
	input  line_status_t status_rdata,
	input  logic         mem_ready,
	output logic         proc_stall,
	output logic         status_we,
	output line_status_t status_wdata,
	output logic         data_we,
	output logic         fill_sel,
	output logic         mem_read,
	output logic         mem_write,
	output mem_addr_t    mem_addr
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	tag_t      req_tag;
	index_t    req_index;
	mem_addr_t req_block;
	logic      request;
	logic      tag_match;
	logic      hit;
	logic      miss;

	// address fields of the pending request
	assign req_tag   = proc_addr[ADDR_W-1 -: TAG_W];
	assign req_index = proc_addr[OFFSET_W +: INDEX_W];
	assign req_block = proc_addr[ADDR_W-1:OFFSET_W];

	assign request   = proc_read || proc_write;
	assign tag_match = (status_rdata.tag == req_tag);

	// hits are only served while idle in LOOKUP
	assign hit  = (state == LOOKUP) && status_rdata.valid && tag_match;
	assign miss = (state == LOOKUP) && request && !hit;

	always_ff @(posedge clk or posedge proc_reset)
	begin
		if (proc_reset)
		begin
			state <= LOOKUP;
		end
		else
		begin
			state <= next_state;
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			LOOKUP:
			begin
				if (miss)
				begin
					// only the indexed line decides on write-back
					if (status_rdata.dirty)
					begin
						next_state = WRITE_BACK;
					end
					else
					begin
						next_state = REFILL;
					end
				end
			end
			WRITE_BACK:
			begin
				if (mem_ready)
				begin
					next_state = REFILL;
				end
			end
			REFILL:
			begin
				if (mem_ready)
				begin
					next_state = LOOKUP; // request hits next cycle
				end
			end
			default:
			begin
				next_state = LOOKUP;
			end
		endcase
	end

	// memory strobes and processor stall
	always_comb
	begin
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = req_block;
		case (state)
			LOOKUP:
			begin
				proc_stall = miss;
			end
			WRITE_BACK:
			begin
				mem_write = 1'b1;
				mem_addr  = {status_rdata.tag, req_index}; // victim block
			end
			REFILL:
			begin
				mem_read = 1'b1;
			end
			default:
			begin
				proc_stall = 1'b1;
			end
		endcase
	end

	// line updates for write hits and refills
	always_comb
	begin
		data_we      = 1'b0;
		status_we    = 1'b0;
		fill_sel     = (state == REFILL);
		status_wdata = status_rdata;
		if (hit && proc_write)
		begin
			data_we            = 1'b1;
			status_we          = 1'b1;
			status_wdata.valid = 1'b1;
			status_wdata.dirty = 1'b1;
			status_wdata.tag   = req_tag;
		end
		else if ((state == REFILL) && mem_ready)
		begin
			data_we            = 1'b1;
			status_we          = 1'b1;
			status_wdata.valid = 1'b1;
			status_wdata.dirty = 1'b0; // fresh copy of memory
			status_wdata.tag   = req_tag;
		end
	end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ns

module cache_top
	import cache_geometry_pkg::*;
	import cache_ctrl_pkg::*;
#(
	parameter int LINE_COUNT = cache_geometry_pkg::LINE_COUNT
)
(
	input  logic       clk,
	input  logic       proc_reset,
	input  logic       proc_read,
	input  logic       proc_write,
	input  proc_addr_t proc_addr,
	input  word_t      proc_wdata,
	output logic       proc_stall,
	output word_t      proc_rdata,
	output logic       mem_read,
	output logic       mem_write,
	output mem_addr_t  mem_addr,
	output block_t     mem_wdata,
	input  block_t     mem_rdata,
	input  logic       mem_ready
);

	index_t       line_index;
	line_status_t status_rdata;
	line_status_t status_wdata;
	logic         status_we;
	block_t       data_rdata;
	block_t       data_wdata;
	logic         data_we;
	logic         fill_sel;

	assign line_index = proc_addr[OFFSET_W +: INDEX_W];

	// write-back always sends the indexed line
	assign mem_wdata = data_rdata;

	cache_controller u_controller (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.status_rdata (status_rdata),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.status_we    (status_we),
		.status_wdata (status_wdata),
		.data_we      (data_we),
		.fill_sel     (fill_sel),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr)
	);

	block_datapath u_datapath (
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.data_rdata (data_rdata),
		.mem_rdata  (mem_rdata),
		.fill_sel   (fill_sel),
		.data_wdata (data_wdata),
		.rd_word    (proc_rdata)
	);

	// valid, dirty and tag per line
	line_array #(
		.entry_t    (line_status_t),
		.LINE_COUNT (LINE_COUNT)
	) status_array (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (line_index),
		.we         (status_we),
		.wdata      (status_wdata),
		.rdata      (status_rdata)
	);

	// 128-bit data blocks
	line_array #(
		.entry_t    (block_t),
		.LINE_COUNT (LINE_COUNT)
	) data_array (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (line_index),
		.we         (data_we),
		.wdata      (data_wdata),
		.rdata      (data_rdata)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen
(
	output logic clk,
	output logic proc_reset
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial
	begin
		proc_reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0; // released away from the rising edge
	end

endmodule

/* tb/memory_model.sv */
`timescale 1ns/1ns

module memory_model
	import cache_geometry_pkg::*;
#(
	parameter int BLOCKS = 256
)
(
	input  logic      clk,
	input  logic      proc_reset,
	input  logic      mem_read,
	input  logic      mem_write,
	input  mem_addr_t mem_addr,
	input  block_t    mem_wdata,
	output block_t    mem_rdata,
	output logic      mem_ready
);

	block_t blocks [BLOCKS];
	logic   busy;
	int     delay;

	// every word starts as a function of its full word address
	initial
	begin
		mem_ready = 1'b0;
		mem_rdata = '0;
		busy      = 1'b0;
		delay     = 0;
		for (int a = 0; a < BLOCKS * WORDS_PER_LINE; a++)
		begin
			blocks[a / WORDS_PER_LINE][(a % WORDS_PER_LINE) * WORD_W +: WORD_W] =
				{2'b10, 30'(a)} ^ 32'h3c5a_0f00;
		end
	end

	always @(negedge clk or posedge proc_reset)
	begin
		if (proc_reset)
		begin
			mem_ready <= 1'b0;
			busy      <= 1'b0;
		end
		else if (mem_ready)
		begin
			mem_ready <= 1'b0; // transfer ended at the last rising edge
			busy      <= 1'b0;
		end
		else if ((mem_read || mem_write) && !busy)
		begin
			busy  <= 1'b1;
			delay <= $urandom_range(5, 0);
		end
		else if (busy && (delay > 0))
		begin
			delay <= delay - 1;
		end
		else if (busy)
		begin
			mem_ready <= 1'b1;
			mem_rdata <= blocks[mem_addr];
		end
	end

	always @(posedge clk)
	begin
		if (mem_write && mem_ready)
		begin
			blocks[mem_addr] <= mem_wdata; // write-back lands here
		end
	end

endmodule

/* tb/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb
	import cache_geometry_pkg::*;
();

	logic       clk;
	logic       proc_reset;
	logic       proc_read;
	logic       proc_write;
	proc_addr_t proc_addr;
	word_t      proc_wdata;
	logic       proc_stall;
	word_t      proc_rdata;
	logic       mem_read;
	logic       mem_write;
	mem_addr_t  mem_addr;
	block_t     mem_wdata;
	block_t     mem_rdata;
	logic       mem_ready;

	word_t arch [1024];    // what the processor should see
	word_t backing [1024]; // what memory should hold
	logic  line_valid [LINE_COUNT];
	logic  line_dirty [LINE_COUNT];
	tag_t  line_tag [LINE_COUNT];
	int    errors;
	int    checks;
	int    tests_run;
	int    tests_failed;

	tb_clock_gen clock_gen (.*);

	memory_model mem_model (.*);

	cache_top #(.LINE_COUNT(LINE_COUNT)) UUT (.*);

	task automatic compare_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		assert (got === exp) else
		begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else
		begin
			$display("%s at %0t ns", what, $time);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
		begin
			$display("%s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("test failed");
		$finish;
	endtask

	function automatic block_t expected_block(input mem_addr_t blk);
		block_t b;
		for (int w = 0; w < WORDS_PER_LINE; w++)
		begin
			b[w*WORD_W +: WORD_W] = arch[{blk, 2'b00} + w];
		end
		return b;
	endfunction

	// one processor request, checked against the reference model
	task automatic access(input logic wr, input proc_addr_t addr, input word_t data);
		index_t idx;
		tag_t   tg;
		logic   miss;
		logic   seen_wb;
		logic   seen_rd;
		logic   done;
		int     base;
		idx     = addr[OFFSET_W +: INDEX_W];
		tg      = addr[ADDR_W-1 -: TAG_W];
		miss    = !line_valid[idx] || (line_tag[idx] != tg);
		seen_wb = 1'b0;
		seen_rd = 1'b0;
		done    = 1'b0;
		@(negedge clk);
		proc_read  = !wr;
		proc_write = wr;
		proc_addr  = addr;
		proc_wdata = data;
		for (int cycles = 0; cycles < 200 && !done; cycles++)
		begin
			@(posedge clk);
			if (mem_write)
			begin
				expect_true(miss && line_dirty[idx] && !seen_rd, "mem_write without a dirty miss");
				compare_value("mem_addr", mem_addr, {line_tag[idx], idx});
				compare_value("mem_wdata", mem_wdata, expected_block({line_tag[idx], idx}));
				seen_wb = seen_wb || mem_ready;
			end
			if (mem_read)
			begin
				expect_true(miss && (seen_wb || !line_dirty[idx]), "mem_read out of order");
				compare_value("mem_addr", mem_addr, addr[ADDR_W-1:OFFSET_W]);
				seen_rd = seen_rd || mem_ready;
			end
			done = !proc_stall;
		end
		if (!done)
			abort_on_timeout("proc_stall low");
		if (!wr)
			compare_value("proc_rdata", proc_rdata, arch[addr]);
		expect_true(seen_rd == miss, "refill missing or not expected");
		expect_true(seen_wb == (miss && line_dirty[idx]), "write-back missing or not expected");
		if (miss)
		begin
			base = {line_tag[idx], idx, 2'b00};
			for (int w = 0; w < WORDS_PER_LINE; w++)
			begin
				if (line_dirty[idx])
					backing[base + w] = arch[base + w];
			end
			line_valid[idx] = 1'b1;
			line_dirty[idx] = 1'b0;
			line_tag[idx]   = tg;
		end
		if (wr)
		begin
			arch[addr]      = data;
			line_dirty[idx] = 1'b1;
		end
	endtask

	initial
	begin
		int     errs;
		block_t blk;
		block_t exp_blk;
		void'($urandom(32'hba0f_d164));
		proc_read    = 1'b0;
		proc_write   = 1'b0;
		proc_addr    = '0;
		proc_wdata   = '0;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (int i = 0; i < 1024; i++)
		begin
			arch[i]    = {2'b10, 30'(i)} ^ 32'h3c5a_0f00; // memory's start pattern
			backing[i] = arch[i];
		end
		for (int i = 0; i < LINE_COUNT; i++)
		begin
			line_valid[i] = 1'b0;
			line_dirty[i] = 1'b0;
			line_tag[i]   = '0;
		end
		for (int cycles = 0; cycles < 50 && proc_reset !== 1'b0; cycles++)
			@(negedge clk);
		if (proc_reset !== 1'b0)
			abort_on_timeout("reset release");

		errs = errors;
		@(posedge clk);
		compare_value("proc_stall", proc_stall, 1'b0);
		compare_value("mem_read", mem_read, 1'b0);
		compare_value("mem_write", mem_write, 1'b0);
		finish_test("idle after reset", errs);

		errs = errors;
		access(1'b0, 30'h046, '0); // index 1, tag 2
		finish_test("clean read miss", errs);

		errs = errors;
		access(1'b1, 30'h089, 32'hdead_beef);
		for (int i = 0; i < WORDS_PER_LINE; i++)
			access(1'b0, 30'h088 + i, '0);
		finish_test("write then block reads", errs);

		errs = errors;
		access(1'b0, 30'h0a9, '0); // evicts the dirty tag 4 block
		finish_test("dirty conflict miss", errs);

		errs = errors;
		access(1'b0, 30'h066, '0); // evicts the clean tag 2 block
		finish_test("clean conflict miss", errs);

		errs = errors;
		for (int n = 0; n < 200; n++)
			access($urandom_range(1, 0) == 1, proc_addr_t'($urandom_range(255, 0)), $urandom);
		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
		for (int b = 0; b < 256; b++)
		begin
			blk = mem_model.blocks[b];
			for (int w = 0; w < WORDS_PER_LINE; w++)
				exp_blk[w*WORD_W +: WORD_W] = backing[b*WORDS_PER_LINE + w];
			compare_value("mem_model.blocks", blk, exp_blk);
		end
		finish_test("random traffic", errs);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* build.f */
hw/cache_geometry_pkg.sv
hw/cache_ctrl_pkg.sv
hw/line_array.sv
hw/block_datapath.sv
hw/cache_controller.sv
hw/cache_top.sv
tb/tb_clock_gen.sv
tb/memory_model.sv
tb/cache_tb.sv
